// File: common/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

////////////////////
// core widths

// data word width
`define CPU_XLEN 32

// architectural register count
`define CPU_NUM_REGS 32

// register select, log2 of the count
`define CPU_REG_SEL_W 5

////////////////////
// instruction fields

// immediate field in the immediate form
// sign extended to CPU_XLEN in decode
`define CPU_IMM_W 16

`endif

// File: common/cpu_pkg.sv
package cpu_pkg;

`include "cpu_cfg.svh"

    ////////////////////
    // basic types

    // one data word
    typedef logic [`CPU_XLEN-1:0] word_t;

    // register index
    typedef logic [`CPU_REG_SEL_W-1:0] reg_sel_t;

    // alu op codes, same 5 bit field as the instruction op
    // codes above op_lui are undefined and run as op_nop
    typedef enum logic [4:0] {
        op_nop = 5'd0,
        op_add = 5'd1,
        op_sub = 5'd2,
        op_and = 5'd3,
        op_or  = 5'd4,
        op_xor = 5'd5,
        op_sll = 5'd6,
        op_srl = 5'd7,
        op_slt = 5'd8,
        op_lui = 5'd9
    } alu_op_e;

    ////////////////////
    // instruction word

    // register form, imm flag clear
    typedef struct packed {
        logic [4:0] op;
        logic       use_imm;
        reg_sel_t   rd;
        reg_sel_t   rs1;
        reg_sel_t   rs2;
        logic [`CPU_XLEN-6-3*`CPU_REG_SEL_W-1:0] unused;
    } instr_reg_t;

    // immediate form, imm flag set
    // low half is a signed immediate
    typedef struct packed {
        logic [4:0]            op;
        logic                  use_imm;
        reg_sel_t              rd;
        reg_sel_t              rs1;
        logic [`CPU_IMM_W-1:0] imm;
    } instr_imm_t;

    // both views of one word
    typedef union packed {
        instr_reg_t r;
        instr_imm_t i;
    } instr_u;

endpackage

// File: hdl/reg_file.sv
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  cpu_pkg::reg_sel_t rd1_sel,
    input  cpu_pkg::reg_sel_t rd2_sel,
    output cpu_pkg::word_t    rd1_data,
    output cpu_pkg::word_t    rd2_data,
    input  logic              rf_wrt_en,
    input  cpu_pkg::reg_sel_t rf_wrt_sel,
    input  cpu_pkg::word_t    rf_wrt_data
);
    import cpu_pkg::*;

    // register array
    word_t regs [`CPU_NUM_REGS];

    ////////////////////
    // write port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `CPU_NUM_REGS; i++)
                regs[i] <= '0;
        end else if (rf_wrt_en) begin
            regs[rf_wrt_sel] <= rf_wrt_data;
        end
    end

    ////////////////////
    // read ports
    // no write bypass, execute forwards the same-cycle value
    assign rd1_data = (rd1_sel == '0) ? '0 : regs[rd1_sel];
    assign rd2_data = (rd2_sel == '0) ? '0 : regs[rd2_sel];

    // register 0 is never a write target
    a_no_wrt_r0: assert property (@(posedge clk) disable iff (!rst_n)
        rf_wrt_en |-> (rf_wrt_sel != '0));

endmodule

// File: hdl/instr_decode.sv
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module instr_decode (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  cpu_pkg::instr_u   instr,
    output logic              de_valid,
    output cpu_pkg::alu_op_e  de_op,
    output cpu_pkg::reg_sel_t de_rs1,
    output cpu_pkg::reg_sel_t de_rs2,
    output cpu_pkg::reg_sel_t de_rd,
    output logic              de_use_imm,
    output cpu_pkg::word_t    de_imm,
    output logic              de_wrt_en
);
    import cpu_pkg::*;

    ////////////////////
    // field split
    logic       is_imm;
    logic [4:0] raw_op;
    alu_op_e    dec_op;
    reg_sel_t   dec_rd;
    reg_sel_t   dec_rs1;
    reg_sel_t   dec_rs2;
    word_t      dec_imm;
    logic       dec_wrt_en;

    // flag bit sits at the same place in both views
    assign is_imm = instr.i.use_imm;

    always_comb begin
        // op, rd and rs1 share their bits in both views
        raw_op  = instr.r.op;
        dec_rd  = instr.r.rd;
        dec_rs1 = instr.r.rs1;
        if (is_imm) begin
            // no second source register here
            dec_rs2 = '0;
            // sign extend the low half
            dec_imm = {{(`CPU_XLEN-`CPU_IMM_W){instr.i.imm[`CPU_IMM_W-1]}}, instr.i.imm};
        end else begin
            dec_rs2 = instr.r.rs2;
            dec_imm = '0;
        end
        // undefined codes fold to nop
        if (raw_op > op_lui)
            dec_op = op_nop;
        else
            dec_op = alu_op_e'(raw_op);
    end

    // only real writes to a nonzero register go down the pipe
    assign dec_wrt_en = instr_valid && (dec_op != op_nop) && (dec_rd != '0);

    ////////////////////
    // decode register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            de_valid  <= 1'b0;
            de_wrt_en <= 1'b0;
            de_op     <= op_nop;
        end else begin
            de_valid  <= instr_valid;
            de_wrt_en <= dec_wrt_en;
            // bubbles carry a nop
            de_op     <= instr_valid ? dec_op : op_nop;
        end
    end

    // payload, no reset
    always_ff @(posedge clk) begin
        de_rs1     <= dec_rs1;
        de_rs2     <= dec_rs2;
        de_rd      <= dec_rd;
        de_use_imm <= is_imm;
        de_imm     <= dec_imm;
    end

    // op handed to execute is always one the alu knows
    a_de_op_defined: assert property (@(posedge clk) disable iff (!rst_n)
        de_op inside {op_nop, op_add, op_sub, op_and, op_or, op_xor,
                      op_sll, op_srl, op_slt, op_lui});

endmodule

// File: execute/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              de_valid,
    input  cpu_pkg::alu_op_e  de_op,
    input  cpu_pkg::reg_sel_t de_rs1,
    input  cpu_pkg::reg_sel_t de_rs2,
    input  cpu_pkg::reg_sel_t de_rd,
    input  logic              de_use_imm,
    input  logic              de_wrt_en,
    input  cpu_pkg::word_t    de_imm,
    output cpu_pkg::reg_sel_t rd1_sel,
    output cpu_pkg::reg_sel_t rd2_sel,
    input  cpu_pkg::word_t    rd1_data,
    input  cpu_pkg::word_t    rd2_data,
    input  logic              rf_wrt_en,
    input  cpu_pkg::reg_sel_t rf_wrt_sel,
    input  cpu_pkg::word_t    rf_wrt_data,
    output logic              ex_wrt_en,
    output cpu_pkg::reg_sel_t ex_rd,
    output cpu_pkg::word_t    ex_result
);
    import cpu_pkg::*;

    word_t src_a;
    word_t src_b_reg;
    word_t src_b;
    word_t alu_out;

    // register file read selects straight from decode
    assign rd1_sel = de_rs1;
    assign rd2_sel = de_rs2;

    ////////////////////
    // forwarding

    // youngest producer wins, then result stage, then the file
    // rd 0 never carries a write enable so no zero check here
    function automatic word_t fwd_pick(input reg_sel_t sel, input word_t rf_data);
        word_t val;
        if (ex_wrt_en && (ex_rd == sel))
            val = ex_result;
        else if (rf_wrt_en && (rf_wrt_sel == sel))
            val = rf_wrt_data;
        else
            val = rf_data;
        return val;
    endfunction

    always_comb begin
        src_a     = fwd_pick(de_rs1, rd1_data);
        src_b_reg = fwd_pick(de_rs2, rd2_data);
    end

    // immediate form replaces operand b
    assign src_b = de_use_imm ? de_imm : src_b_reg;

    ////////////////////
    // alu
    always_comb begin
        case (de_op)
            op_add: alu_out = src_a + src_b;
            op_sub: alu_out = src_a - src_b;
            op_and: alu_out = src_a & src_b;
            op_or:  alu_out = src_a | src_b;
            op_xor: alu_out = src_a ^ src_b;
            // shift amount is the low 5 bits of b
            op_sll: alu_out = src_a << src_b[4:0];
            op_srl: alu_out = src_a >> src_b[4:0];
            // signed compare, 1 or 0
            op_slt: alu_out = ($signed(src_a) < $signed(src_b)) ? word_t'(1) : '0;
            // pass b through
            op_lui: alu_out = src_b;
            default: alu_out = '0;
        endcase
    end

    ////////////////////
    // execute/result register
    always_ff @(posedge clk) begin
        if (!rst_n)
            ex_wrt_en <= 1'b0;
        else
            ex_wrt_en <= de_valid && de_wrt_en;
    end

    // payload
    always_ff @(posedge clk) begin
        ex_rd     <= de_rd;
        ex_result <= alu_out;
    end

    // decode keeps rd 0 writes out of the pipe
    a_no_ex_wrt_r0: assert property (@(posedge clk) disable iff (!rst_n)
        ex_wrt_en |-> (ex_rd != '0));

endmodule

// File: hdl/result_writeback.sv
`timescale 1ns/1ps

module result_writeback (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              ex_wrt_en,
    input  cpu_pkg::reg_sel_t ex_rd,
    input  cpu_pkg::word_t    ex_result,
    output logic              rf_wrt_en,
    output cpu_pkg::reg_sel_t rf_wrt_sel,
    output cpu_pkg::word_t    rf_wrt_data
);
    import cpu_pkg::*;

    ////////////////////
    // last pipe register

    // write enable, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n)
            rf_wrt_en <= 1'b0;
        else
            rf_wrt_en <= ex_wrt_en;
    end

    // select and data only matter with the enable
    always_ff @(posedge clk) begin
        rf_wrt_sel  <= reg_sel_t'(ex_rd);
        rf_wrt_data <= word_t'(ex_result);
    end

    // outputs feed three places
    // register file write port
    // second forward source in execute
    // retire report at the top

endmodule

// File: hdl/cpu.sv
`timescale 1ns/1ps

module cpu (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              instr_valid,
    input  cpu_pkg::instr_u   instr,
    output logic              wb_valid,
    output cpu_pkg::reg_sel_t wb_sel,
    output cpu_pkg::word_t    wb_data
);
    import cpu_pkg::*;

    ////////////////////
    // decode to execute
    logic     de_valid;
    alu_op_e  de_op;
    reg_sel_t de_rs1;
    reg_sel_t de_rs2;
    reg_sel_t de_rd;
    logic     de_use_imm;
    word_t    de_imm;
    logic     de_wrt_en;

    // register file read ports
    reg_sel_t rd1_sel;
    reg_sel_t rd2_sel;
    word_t    rd1_data;
    word_t    rd2_data;

    ////////////////////
    // execute to result
    logic     ex_wrt_en;
    reg_sel_t ex_rd;
    word_t    ex_result;

    // result stage, also the late forward source
    logic     rf_wrt_en;
    reg_sel_t rf_wrt_sel;
    word_t    rf_wrt_data;

    instr_decode i_decode (
        .clk(clk),
        .rst_n(rst_n),
        .instr_valid(instr_valid),
        .instr(instr),
        .de_valid(de_valid),
        .de_op(de_op),
        .de_rs1(de_rs1),
        .de_rs2(de_rs2),
        .de_rd(de_rd),
        .de_use_imm(de_use_imm),
        .de_imm(de_imm),
        .de_wrt_en(de_wrt_en)
    );

    alu_execute i_execute (
        .clk(clk), .rst_n(rst_n), .de_valid(de_valid), .de_op(de_op),
        .de_rs1(de_rs1), .de_rs2(de_rs2), .de_rd(de_rd),
        .de_use_imm(de_use_imm), .de_wrt_en(de_wrt_en), .de_imm(de_imm),
        .rd1_sel(rd1_sel), .rd2_sel(rd2_sel),
        .rd1_data(rd1_data), .rd2_data(rd2_data),
        .rf_wrt_en(rf_wrt_en), .rf_wrt_sel(rf_wrt_sel), .rf_wrt_data(rf_wrt_data),
        .ex_wrt_en(ex_wrt_en), .ex_rd(ex_rd), .ex_result(ex_result)
    );

    result_writeback i_result (
        .clk(clk), .rst_n(rst_n),
        .ex_wrt_en(ex_wrt_en), .ex_rd(ex_rd), .ex_result(ex_result),
        .rf_wrt_en(rf_wrt_en), .rf_wrt_sel(rf_wrt_sel), .rf_wrt_data(rf_wrt_data)
    );

    reg_file i_reg_file (
        .clk(clk), .rst_n(rst_n),
        .rd1_sel(rd1_sel), .rd2_sel(rd2_sel),
        .rd1_data(rd1_data), .rd2_data(rd2_data),
        .rf_wrt_en(rf_wrt_en), .rf_wrt_sel(rf_wrt_sel), .rf_wrt_data(rf_wrt_data)
    );

    // retire report is the register file write port
    assign wb_valid = rf_wrt_en;
    assign wb_sel   = rf_wrt_sel;
    assign wb_data  = rf_wrt_data;

endmodule

// File: testbench/cpu_tb.sv
`timescale 1ns/1ps

`include "cpu_cfg.svh"

module cpu_tb;
    import cpu_pkg::*;

    // one expected retire, tagged with its issue cycle
    typedef struct packed {
        logic        valid;
        reg_sel_t    sel;
        word_t       data;
        int unsigned cyc;
    } exp_t;

    logic     clk;
    logic     rst_n;
    logic     instr_valid;
    instr_u   instr;
    logic     wb_valid;
    reg_sel_t wb_sel;
    word_t    wb_data;

    integer      seed;
    int unsigned cycle = 0;
    int          mismatches = 0;
    int          stray_writes = 0;
    int          timeouts = 0;
    word_t       model_regs [`CPU_NUM_REGS];
    exp_t        exp_q [$];

    cpu dut_i (
        .clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
        .wb_valid(wb_valid), .wb_sel(wb_sel), .wb_data(wb_data)
    );

    // 20 ns period
    always #10 clk = ~clk;

    // cycle count for the latency check
    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////
    // reference model

    // architectural result of one instruction, in program order
    function automatic exp_t ref_result(input word_t regs [`CPU_NUM_REGS], input instr_u ins);
        exp_t  e;
        word_t a;
        word_t b;
        a = regs[ins.r.rs1];
        // imm form takes a sign extended low half as operand b
        b = ins.r.use_imm ? {{16{ins.i.imm[15]}}, ins.i.imm} : regs[ins.r.rs2];
        e.sel   = ins.r.rd;
        e.cyc   = 0;
        e.valid = (ins.r.rd != '0);
        case (ins.r.op)
            op_add: e.data = a + b;
            op_sub: e.data = a - b;
            op_and: e.data = a & b;
            op_or:  e.data = a | b;
            op_xor: e.data = a ^ b;
            op_sll: e.data = a << b[4:0];
            op_srl: e.data = a >> b[4:0];
            op_slt: e.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            op_lui: e.data = b;
            // nop and undefined codes write nothing
            default: begin
                e.valid = 1'b0;
                e.data  = '0;
            end
        endcase
        return e;
    endfunction

    function automatic instr_u enc_reg(input logic [4:0] op, input reg_sel_t rd,
                                       input reg_sel_t rs1, input reg_sel_t rs2);
        instr_u u;
        u       = '0;
        u.r.op  = op;
        u.r.rd  = rd;
        u.r.rs1 = rs1;
        u.r.rs2 = rs2;
        return u;
    endfunction

    function automatic instr_u enc_imm(input logic [4:0] op, input reg_sel_t rd,
                                       input reg_sel_t rs1, input logic [15:0] imm);
        instr_u u;
        u           = '0;
        u.i.op      = op;
        u.i.use_imm = 1'b1;
        u.i.rd      = rd;
        u.i.rs1     = rs1;
        u.i.imm     = imm;
        return u;
    endfunction

    ////////////////////
    // checks

    task automatic check_wb_sel(input reg_sel_t got, input reg_sel_t want);
        if (got !== want) begin
            $display("mismatch at %0t: wb_sel is r%0d, expected r%0d", $time, got, want);
            mismatches++;
        end
    endtask

    task automatic check_wb_data(input word_t got, input word_t want);
        if (got !== want) begin
            $display("mismatch at %0t: wb_data is %h, expected %h", $time, got, want);
            mismatches++;
        end
    endtask

    task automatic check_latency(input int unsigned got);
        if (got != 3) begin
            $display("mismatch at %0t: retired %0d cycles after issue, expected 3", $time, got);
            mismatches++;
        end
    endtask

    // retire watcher on the falling edge, outputs settled
    always @(negedge clk) begin : compare_wb
        exp_t e;
        if (wb_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("register r%0d was written at %0t with no write pending", wb_sel, $time);
                stray_writes++;
            end else begin
                e = exp_q.pop_front();
                check_wb_sel(wb_sel, e.sel);
                check_wb_data(wb_data, e.data);
                check_latency(cycle - e.cyc);
            end
        end
    end

    ////////////////////
    // stimulus

    // one issue slot, driven just after the edge
    task automatic issue(input logic vld, input instr_u ins);
        exp_t e;
        @(posedge clk);
        #2;
        instr_valid = vld;
        instr       = ins;
        if (vld) begin
            e = ref_result(model_regs, ins);
            if (e.valid) begin
                e.cyc = cycle;
                exp_q.push_back(e);
                model_regs[e.sel] = e.data;
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out with %0d expected writes never retired", exp_q.size());
            timeouts++;
        end
    endtask

    initial begin
        word_t  rnd;
        word_t  rnd2;
        instr_u cur;
        clk         = 1'b0;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        seed        = 32'h54a8177d;
        for (int i = 0; i < `CPU_NUM_REGS; i++)
            model_regs[i] = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        // idle, nothing may retire
        repeat (4) issue(1'b0, '0);
        // first reads see the cleared file
        issue(1'b1, enc_reg(op_add, 5'd5, 5'd7, 5'd9));
        issue(1'b1, enc_imm(op_or, 5'd6, 5'd31, 16'h0000));
        // load every register, lui then shift and xor
        for (int k = 1; k < 32; k++) begin
            rnd = $random(seed);
            issue(1'b1, enc_imm(op_lui, k[4:0], 5'd0, rnd[15:0]));
            issue(1'b1, enc_imm(op_sll, k[4:0], k[4:0], 16'd16));
            issue(1'b1, enc_imm(op_xor, k[4:0], k[4:0], rnd[31:16]));
        end
        // every defined op in register form
        for (int k = 1; k <= 9; k++) begin
            repeat (4) begin
                rnd = $random(seed);
                issue(1'b1, enc_reg(k[4:0], (rnd[4:0] == 5'd0) ? 5'd1 : rnd[4:0],
                                    rnd[9:5], rnd[14:10]));
            end
        end
        // immediates of both signs
        issue(1'b1, enc_imm(op_add, 5'd3, 5'd4, 16'h7fff));
        issue(1'b1, enc_imm(op_add, 5'd3, 5'd3, 16'h8000));
        issue(1'b1, enc_imm(op_lui, 5'd2, 5'd0, 16'hfff0));
        issue(1'b1, enc_imm(op_slt, 5'd8, 5'd9, 16'hffff));
        issue(1'b1, enc_imm(op_and, 5'd9, 5'd1, 16'hff00));
        // dependency at distance 1, 2 and 3 on rs1 then rs2
        for (int d = 1; d <= 3; d++) begin
            rnd = $random(seed);
            issue(1'b1, enc_imm(op_add, 5'd10, 5'd3, rnd[15:0]));
            for (int f = 1; f < d; f++)
                issue(1'b1, enc_reg(op_xor, 5'd20 + f[4:0], 5'd4, 5'd5));
            issue(1'b1, enc_reg(op_sub, 5'd11, 5'd10, 5'd6));
            for (int f = 1; f < d; f++)
                issue(1'b1, enc_reg(op_or, 5'd22 + f[4:0], 5'd4, 5'd5));
            issue(1'b1, enc_reg(op_add, 5'd12, 5'd7, 5'd11));
        end
        // two producers in flight, younger one must win
        issue(1'b1, enc_imm(op_lui, 5'd14, 5'd0, 16'h1234));
        issue(1'b1, enc_imm(op_add, 5'd14, 5'd14, 16'h0001));
        issue(1'b1, enc_reg(op_add, 5'd15, 5'd14, 5'd14));
        repeat (4) issue(1'b1, enc_reg(op_add, 5'd13, 5'd13, 5'd14));
        // suppressed writes, r0 target, nop, undefined codes
        issue(1'b1, enc_reg(op_add, 5'd0, 5'd1, 5'd2));
        issue(1'b1, enc_imm(op_lui, 5'd0, 5'd0, 16'h5555));
        issue(1'b1, enc_reg(op_nop, 5'd16, 5'd1, 5'd2));
        for (int k = 10; k < 32; k++)
            issue(1'b1, enc_reg(k[4:0], 5'd17, 5'd1, 5'd2));
        issue(1'b1, enc_reg(op_or, 5'd18, 5'd0, 5'd0));
        issue(1'b1, enc_reg(op_add, 5'd19, 5'd16, 5'd17));
        // random stream with gaps, some undefined codes
        for (int n = 0; n < 150; n++) begin
            rnd  = $random(seed);
            rnd2 = $random(seed);
            if (rnd2[8])
                repeat (rnd2[10:9]) issue(1'b0, rnd2);
            cur = rnd;
            if (rnd2[7:4] != 4'd0)
                cur.r.op = {1'b0, rnd2[3:0]};
            issue(1'b1, cur);
        end
        issue(1'b0, '0);
        wait_drain();
        // quiet tail, catches late stray pulses
        repeat (8) @(posedge clk);
        $display("errors: %0d mismatches, %0d stray writes, %0d timeouts",
                 mismatches, stray_writes, timeouts);
        if (mismatches == 0 && stray_writes == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

// File: cpu.f
+incdir+common
common/cpu_pkg.sv
hdl/reg_file.sv
hdl/instr_decode.sv
execute/alu_execute.sv
hdl/result_writeback.sv
hdl/cpu.sv
testbench/cpu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the cpu testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module cpu_tb -f cpu.f --Mdir obj_dir

./obj_dir/Vcpu_tb | tee sim.log

if grep -qx ">>> PASS" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi
